// ==== Makefile ====
TOP = tb_lsu_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ns --top-module $(TOP) -f compile.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir

// ==== compile.f ====
hdl/lsu_pkg.sv
hdl/cache_pkg.sv
hdl/lsu.sv
hdl/dcache.sv
hdl/uncache_channel.sv
hdl/lsu_top.sv
test/tb_clock.sv
test/tb_lsu_top.sv

// ==== hdl/cache_pkg.sv ====
package cache_pkg;

    // Direct-mapped, one word per line
    localparam int LINES   = 16;
    localparam int INDEX_W = $clog2(LINES);
    localparam int TAG_W   = lsu_pkg::ADDR_W - INDEX_W - 2;

    typedef enum logic [1:0] {
        C_IDLE,
        C_LOOKUP,
        C_BUS
    } dcache_state_e;

    typedef enum logic {
        U_IDLE,
        U_BUS
    } uncache_state_e;

endpackage

// ==== hdl/dcache.sv ====
`timescale 1ns/1ns

module dcache (
    input  logic                       clk,
    input  logic                       rst,
    // LSU side
    input  logic                       dcache_valid,
    input  logic [lsu_pkg::ADDR_W-1:0] dcache_addr,
    input  logic [lsu_pkg::DATA_W-1:0] dcache_wdata,
    input  logic [lsu_pkg::NBYTES-1:0] dcache_wstrb,
    output logic [lsu_pkg::DATA_W-1:0] dcache_rdata,
    output logic                       dcache_ready,
    // Wishbone master
    output logic                       dc_wb_cyc,
    output logic                       dc_wb_stb,
    output logic                       dc_wb_we,
    output logic [lsu_pkg::ADDR_W-1:0] dc_wb_adr,
    output logic [lsu_pkg::DATA_W-1:0] dc_wb_dat_o,
    output logic [lsu_pkg::NBYTES-1:0] dc_wb_sel,
    input  logic [lsu_pkg::DATA_W-1:0] dc_wb_dat_i,
    input  logic                       dc_wb_ack
);

    cache_pkg::dcache_state_e state;
    cache_pkg::dcache_state_e next_state;

    // Request under lookup
    logic [lsu_pkg::ADDR_W-1:0] lk_addr;
    logic [lsu_pkg::DATA_W-1:0] lk_wdata;
    logic [lsu_pkg::NBYTES-1:0] lk_wstrb;
    logic                       lk_store;

    logic [cache_pkg::INDEX_W-1:0] index;
    logic [cache_pkg::TAG_W-1:0]   tag;
    logic                          hit;
    logic                          take;
    logic                          bus_done;

    logic [cache_pkg::LINES-1:0] line_valid;
    logic [cache_pkg::TAG_W-1:0] tag_mem [cache_pkg::LINES];
    logic [lsu_pkg::DATA_W-1:0]  data_mem [cache_pkg::LINES];

    assign lk_store = lk_wstrb != '0;
    assign index    = lk_addr[cache_pkg::INDEX_W+1:2];
    assign tag      = lk_addr[lsu_pkg::ADDR_W-1:cache_pkg::INDEX_W+2];
    assign hit      = line_valid[index] && (tag_mem[index] == tag);
    assign bus_done = (state == cache_pkg::C_BUS) && dc_wb_ack;

    // Load hit frees lookup for the next request in the same cycle
    assign take = dcache_valid &&
        (state == cache_pkg::C_IDLE || (state == cache_pkg::C_LOOKUP && hit && !lk_store));

    assign dcache_ready = (state == cache_pkg::C_LOOKUP && hit && !lk_store) || bus_done;
    assign dcache_rdata = (state == cache_pkg::C_BUS) ? dc_wb_dat_i : data_mem[index];

    assign dc_wb_cyc   = state == cache_pkg::C_BUS;
    assign dc_wb_stb   = state == cache_pkg::C_BUS;
    assign dc_wb_we    = lk_store;
    assign dc_wb_adr   = {lk_addr[lsu_pkg::ADDR_W-1:2], 2'b00};
    assign dc_wb_dat_o = lk_wdata;
    assign dc_wb_sel   = lk_store ? lk_wstrb : {lsu_pkg::NBYTES{1'b1}};

    always_comb begin
        next_state = state;
        case (state)
            cache_pkg::C_IDLE: begin
                if (dcache_valid) begin
                    next_state = cache_pkg::C_LOOKUP;
                end
            end
            cache_pkg::C_LOOKUP: begin
                // Stores always write through
                if (lk_store || !hit) begin
                    next_state = cache_pkg::C_BUS;
                end else if (!dcache_valid) begin
                    next_state = cache_pkg::C_IDLE;
                end
            end
            cache_pkg::C_BUS: begin
                if (dc_wb_ack) begin
                    next_state = cache_pkg::C_IDLE;
                end
            end
            default: next_state = cache_pkg::C_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_pkg::C_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            lk_addr  <= dcache_addr;
            lk_wdata <= dcache_wdata;
            lk_wstrb <= dcache_wstrb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            line_valid <= '0;
        end else if (bus_done && !lk_store) begin
            line_valid[index] <= 1'b1;
        end
    end

    // Refill on a load miss, byte merge on a store hit
    always_ff @(posedge clk) begin
        if (bus_done) begin
            if (!lk_store) begin
                tag_mem[index]  <= tag;
                data_mem[index] <= dc_wb_dat_i;
            end else if (hit) begin
                for (int b = 0; b < lsu_pkg::NBYTES; b++) begin
                    if (lk_wstrb[b]) begin
                        data_mem[index][8*b +: 8] <= lk_wdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

// ==== hdl/lsu.sv ====
`timescale 1ns/1ns

module lsu (
    input  logic                       clk,
    input  logic                       rst,
    // CPU side
    input  logic                       cpu_valid,
    input  logic                       cpu_uncached,
    input  logic [lsu_pkg::ADDR_W-1:0] cpu_addr,
    input  logic [lsu_pkg::DATA_W-1:0] cpu_wdata,
    input  logic [lsu_pkg::NBYTES-1:0] cpu_wstrb,
    input  logic                       cpu_flush,
    input  logic                       cpu_store_commit,
    output logic                       cpu_ready,
    output logic [lsu_pkg::DATA_W-1:0] cpu_rdata,
    output logic                       cpu_data_valid,
    // Data cache
    output logic                       dcache_valid,
    output logic [lsu_pkg::ADDR_W-1:0] dcache_addr,
    output logic [lsu_pkg::DATA_W-1:0] dcache_wdata,
    output logic [lsu_pkg::NBYTES-1:0] dcache_wstrb,
    input  logic [lsu_pkg::DATA_W-1:0] dcache_rdata,
    input  logic                       dcache_ready,
    // Uncache channel
    output logic                       uncache_valid,
    output logic [lsu_pkg::ADDR_W-1:0] uncache_addr,
    output logic [lsu_pkg::DATA_W-1:0] uncache_wdata,
    output logic [lsu_pkg::NBYTES-1:0] uncache_wstrb,
    input  logic [lsu_pkg::DATA_W-1:0] uncache_rdata,
    input  logic                       uncache_ready,
    input  logic                       uncache_data_ok
);

    logic cpu_store;
    logic accept;

    // One-entry request stage
    logic                       req_valid;
    logic                       req_store;
    logic                       req_uncached;
    logic [lsu_pkg::ADDR_W-1:0] req_addr;
    logic [lsu_pkg::DATA_W-1:0] req_wdata;
    logic [lsu_pkg::NBYTES-1:0] req_wstrb;

    lsu_pkg::lsu_state_e state;
    lsu_pkg::lsu_state_e next_state;

    assign cpu_store = cpu_wstrb != '0;

    // A cached load still in lookup blocks the port unless it hits now
    assign cpu_ready = (state == lsu_pkg::IDLE) && (!req_valid || dcache_ready);

    // Flush kills a load or store presented in the same cycle
    assign accept = cpu_valid && cpu_ready && !cpu_flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lsu_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            lsu_pkg::IDLE: begin
                if (req_valid && !req_store && !req_uncached && !dcache_ready) begin
                    next_state = lsu_pkg::REFILL_WAIT;
                end else if (accept && cpu_store) begin
                    next_state = lsu_pkg::STORE_COMMIT_WAIT;
                end else if (accept && cpu_uncached) begin
                    next_state = lsu_pkg::UNCACHE_REQ_SEND;
                end
            end
            lsu_pkg::REFILL_WAIT: begin
                if (dcache_ready) begin
                    next_state = lsu_pkg::IDLE;
                end
            end
            lsu_pkg::STORE_COMMIT_WAIT: begin
                if (cpu_store_commit && req_uncached) begin
                    next_state = lsu_pkg::UNCACHE_REQ_SEND;
                end else if (cpu_store_commit) begin
                    next_state = lsu_pkg::STORE_REQ_SEND;
                end else if (cpu_flush) begin
                    next_state = lsu_pkg::IDLE;
                end
            end
            lsu_pkg::STORE_REQ_SEND: begin
                if (dcache_ready) begin
                    next_state = lsu_pkg::IDLE;
                end else begin
                    next_state = lsu_pkg::STORE_REQ_WAIT;
                end
            end
            lsu_pkg::STORE_REQ_WAIT: begin
                if (dcache_ready) begin
                    next_state = lsu_pkg::IDLE;
                end
            end
            lsu_pkg::UNCACHE_REQ_SEND: begin
                if (uncache_ready) begin
                    next_state = lsu_pkg::UNCACHE_REQ_WAIT;
                end
            end
            lsu_pkg::UNCACHE_REQ_WAIT: begin
                if (uncache_data_ok) begin
                    next_state = lsu_pkg::IDLE;
                end
            end
            default: next_state = lsu_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
        end else if (accept) begin
            req_valid <= 1'b1;
        end else if (state == lsu_pkg::STORE_COMMIT_WAIT && cpu_flush && !cpu_store_commit) begin
            req_valid <= 1'b0;
        end else if (dcache_ready || uncache_data_ok) begin
            req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_store    <= cpu_store;
            req_uncached <= cpu_uncached;
            req_addr     <= cpu_addr;
            req_wdata    <= cpu_wdata;
            req_wstrb    <= cpu_wstrb;
        end
    end

    // Cached loads bypass the request stage on their way in
    always_comb begin
        case (state)
            lsu_pkg::IDLE: dcache_valid = accept && !cpu_store && !cpu_uncached;
            lsu_pkg::REFILL_WAIT,
            lsu_pkg::STORE_REQ_SEND,
            lsu_pkg::STORE_REQ_WAIT: dcache_valid = 1'b1;
            default: dcache_valid = 1'b0;
        endcase
    end

    assign dcache_addr  = (state == lsu_pkg::IDLE) ? cpu_addr : req_addr;
    assign dcache_wdata = (state == lsu_pkg::IDLE) ? cpu_wdata : req_wdata;
    assign dcache_wstrb = (state == lsu_pkg::IDLE) ? cpu_wstrb : req_wstrb;

    // Channel latches the access, so valid is only needed until accepted
    assign uncache_valid = state == lsu_pkg::UNCACHE_REQ_SEND;
    assign uncache_addr  = req_addr;
    assign uncache_wdata = req_wdata;
    assign uncache_wstrb = req_wstrb;

    assign cpu_rdata = (state == lsu_pkg::UNCACHE_REQ_WAIT) ? uncache_rdata : dcache_rdata;

    assign cpu_data_valid =
        ((state == lsu_pkg::IDLE || state == lsu_pkg::REFILL_WAIT) && dcache_ready) ||
        (state == lsu_pkg::UNCACHE_REQ_WAIT && uncache_data_ok && !req_store);

endmodule

// ==== hdl/lsu_pkg.sv ====
package lsu_pkg;

    // Bus and data widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int NBYTES = DATA_W / 8;

    // Load/store unit control states
    typedef enum logic [2:0] {
        IDLE,
        REFILL_WAIT,
        STORE_COMMIT_WAIT,
        STORE_REQ_SEND,
        STORE_REQ_WAIT,
        UNCACHE_REQ_SEND,
        UNCACHE_REQ_WAIT
    } lsu_state_e;

endpackage

// ==== hdl/lsu_top.sv ====
`timescale 1ns/1ns

module lsu_top (
    input  logic                       clk,
    input  logic                       rst,
    // CPU port
    input  logic                       cpu_valid,
    input  logic                       cpu_uncached,
    input  logic [lsu_pkg::ADDR_W-1:0] cpu_addr,
    input  logic [lsu_pkg::DATA_W-1:0] cpu_wdata,
    input  logic [lsu_pkg::NBYTES-1:0] cpu_wstrb,
    input  logic                       cpu_flush,
    input  logic                       cpu_store_commit,
    output logic                       cpu_ready,
    output logic [lsu_pkg::DATA_W-1:0] cpu_rdata,
    output logic                       cpu_data_valid,
    // Cache refill and write-through port
    output logic                       dc_wb_cyc,
    output logic                       dc_wb_stb,
    output logic                       dc_wb_we,
    output logic [lsu_pkg::ADDR_W-1:0] dc_wb_adr,
    output logic [lsu_pkg::DATA_W-1:0] dc_wb_dat_o,
    output logic [lsu_pkg::NBYTES-1:0] dc_wb_sel,
    input  logic [lsu_pkg::DATA_W-1:0] dc_wb_dat_i,
    input  logic                       dc_wb_ack,
    // Peripheral port
    output logic                       io_wb_cyc,
    output logic                       io_wb_stb,
    output logic                       io_wb_we,
    output logic [lsu_pkg::ADDR_W-1:0] io_wb_adr,
    output logic [lsu_pkg::DATA_W-1:0] io_wb_dat_o,
    output logic [lsu_pkg::NBYTES-1:0] io_wb_sel,
    input  logic [lsu_pkg::DATA_W-1:0] io_wb_dat_i,
    input  logic                       io_wb_ack
);

    logic                       dcache_valid;
    logic [lsu_pkg::ADDR_W-1:0] dcache_addr;
    logic [lsu_pkg::DATA_W-1:0] dcache_wdata;
    logic [lsu_pkg::NBYTES-1:0] dcache_wstrb;
    logic [lsu_pkg::DATA_W-1:0] dcache_rdata;
    logic                       dcache_ready;

    logic                       uncache_valid;
    logic [lsu_pkg::ADDR_W-1:0] uncache_addr;
    logic [lsu_pkg::DATA_W-1:0] uncache_wdata;
    logic [lsu_pkg::NBYTES-1:0] uncache_wstrb;
    logic [lsu_pkg::DATA_W-1:0] uncache_rdata;
    logic                       uncache_ready;
    logic                       uncache_data_ok;

    lsu lsu_i (.*);

    dcache dcache_i (.*);

    uncache_channel uncache_i (
        .valid   (uncache_valid),
        .addr    (uncache_addr),
        .wdata   (uncache_wdata),
        .wstrb   (uncache_wstrb),
        .rdata   (uncache_rdata),
        .ready   (uncache_ready),
        .data_ok (uncache_data_ok),
        .*
    );

endmodule

// ==== hdl/uncache_channel.sv ====
`timescale 1ns/1ns

module uncache_channel (
    input  logic                       clk,
    input  logic                       rst,
    // LSU side
    input  logic                       valid,
    input  logic [lsu_pkg::ADDR_W-1:0] addr,
    input  logic [lsu_pkg::DATA_W-1:0] wdata,
    input  logic [lsu_pkg::NBYTES-1:0] wstrb,
    output logic [lsu_pkg::DATA_W-1:0] rdata,
    output logic                       ready,
    output logic                       data_ok,
    // Wishbone master
    output logic                       io_wb_cyc,
    output logic                       io_wb_stb,
    output logic                       io_wb_we,
    output logic [lsu_pkg::ADDR_W-1:0] io_wb_adr,
    output logic [lsu_pkg::DATA_W-1:0] io_wb_dat_o,
    output logic [lsu_pkg::NBYTES-1:0] io_wb_sel,
    input  logic [lsu_pkg::DATA_W-1:0] io_wb_dat_i,
    input  logic                       io_wb_ack
);

    cache_pkg::uncache_state_e state;

    logic [lsu_pkg::ADDR_W-1:0] acc_addr;
    logic [lsu_pkg::DATA_W-1:0] acc_wdata;
    logic [lsu_pkg::NBYTES-1:0] acc_wstrb;

    assign ready = state == cache_pkg::U_IDLE;

    assign io_wb_cyc   = state == cache_pkg::U_BUS;
    assign io_wb_stb   = state == cache_pkg::U_BUS;
    assign io_wb_we    = acc_wstrb != '0;
    assign io_wb_adr   = {acc_addr[lsu_pkg::ADDR_W-1:2], 2'b00};
    assign io_wb_dat_o = acc_wdata;
    assign io_wb_sel   = io_wb_we ? acc_wstrb : {lsu_pkg::NBYTES{1'b1}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= cache_pkg::U_IDLE;
            data_ok <= 1'b0;
        end else begin
            data_ok <= 1'b0;
            if (state == cache_pkg::U_IDLE && valid) begin
                state <= cache_pkg::U_BUS;
            end else if (state == cache_pkg::U_BUS && io_wb_ack) begin
                state   <= cache_pkg::U_IDLE;
                data_ok <= 1'b1;
            end
        end
    end

    // Access fields and read data
    always_ff @(posedge clk) begin
        if (state == cache_pkg::U_IDLE && valid) begin
            acc_addr  <= addr;
            acc_wdata <= wdata;
            acc_wstrb <= wstrb;
        end
        if (state == cache_pkg::U_BUS && io_wb_ack) begin
            rdata <= io_wb_dat_i;
        end
    end

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held over two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== test/tb_lsu_top.sv ====
`timescale 1ns/1ns

module tb_lsu_top;

    logic                       clk;
    logic                       rst;
    logic                       cpu_valid;
    logic                       cpu_uncached;
    logic [lsu_pkg::ADDR_W-1:0] cpu_addr;
    logic [lsu_pkg::DATA_W-1:0] cpu_wdata;
    logic [lsu_pkg::NBYTES-1:0] cpu_wstrb;
    logic                       cpu_flush;
    logic                       cpu_store_commit;
    logic                       cpu_ready;
    logic [lsu_pkg::DATA_W-1:0] cpu_rdata;
    logic                       cpu_data_valid;
    logic                       dc_wb_cyc, dc_wb_stb, dc_wb_we, dc_wb_ack;
    logic [lsu_pkg::ADDR_W-1:0] dc_wb_adr;
    logic [lsu_pkg::DATA_W-1:0] dc_wb_dat_o, dc_wb_dat_i;
    logic [lsu_pkg::NBYTES-1:0] dc_wb_sel;
    logic                       io_wb_cyc, io_wb_stb, io_wb_we, io_wb_ack;
    logic [lsu_pkg::ADDR_W-1:0] io_wb_adr;
    logic [lsu_pkg::DATA_W-1:0] io_wb_dat_o, io_wb_dat_i;
    logic [lsu_pkg::NBYTES-1:0] io_wb_sel;

    // Memory behind both ports, and what it should hold
    logic [lsu_pkg::DATA_W-1:0] bus_mem [256];
    logic [lsu_pkg::DATA_W-1:0] ref_mem [256];
    logic [1:0]                 delay_tab [256];
    logic [lsu_pkg::NBYTES-1:0] dc_last_sel;
    logic [lsu_pkg::NBYTES-1:0] io_last_sel;

    integer seed;
    int     errors;
    int     timeouts;
    int     dc_count;
    int     io_count;
    int     dc_wait;
    int     io_wait;

    tb_clock clock_i (.clk(clk), .rst(rst));

    lsu_top dut_i (.*);

    function automatic logic [31:0] fill_word(input int i);
        return (32'h9e37_79b9 * i) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                          input logic [3:0] sel);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < lsu_pkg::NBYTES; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Tags 0..3 over indices 0..3, so lines alias
    function automatic logic [31:0] cached_addr(input int k);
        return 32'((((k / 4) << cache_pkg::INDEX_W) | (k % 4)) << 2);
    endfunction

    function automatic logic [31:0] uncached_addr(input int k);
        return 32'h8000_0200 + 32'(k * 4);
    endfunction

    // Both Wishbone slaves, 0 to 3 wait states each
    initial begin
        dc_wb_ack = 1'b0;
        dc_wb_dat_i = '0;
        io_wb_ack = 1'b0;
        io_wb_dat_i = '0;
        dc_last_sel = '0;
        io_last_sel = '0;
        dc_wait = -1;
        io_wait = -1;
        dc_count = 0;
        io_count = 0;
        for (int i = 0; i < 256; i++) begin
            bus_mem[i] = fill_word(i);
        end
        forever begin
            @(negedge clk);
            if (dc_wb_ack) begin
                dc_wb_ack = 1'b0;
            end else if (dc_wb_cyc && dc_wb_stb) begin
                if (dc_wait < 0) begin
                    dc_wait = int'(delay_tab[dc_count[7:0]]);
                end
                if (dc_wait == 0) begin
                    dc_wb_dat_i = bus_mem[dc_wb_adr[9:2]];
                    if (dc_wb_we) begin
                        bus_mem[dc_wb_adr[9:2]] = merge(dc_wb_dat_i, dc_wb_dat_o, dc_wb_sel);
                    end
                    dc_last_sel = dc_wb_sel;
                    dc_count++;
                    dc_wb_ack = 1'b1;
                end
                dc_wait--;
            end
            if (io_wb_ack) begin
                io_wb_ack = 1'b0;
            end else if (io_wb_cyc && io_wb_stb) begin
                if (io_wait < 0) begin
                    io_wait = int'(delay_tab[8'(io_count + 128)]);
                end
                if (io_wait == 0) begin
                    io_wb_dat_i = bus_mem[io_wb_adr[9:2]];
                    if (io_wb_we) begin
                        bus_mem[io_wb_adr[9:2]] = merge(io_wb_dat_i, io_wb_dat_o, io_wb_sel);
                    end
                    io_last_sel = io_wb_sel;
                    io_count++;
                    io_wb_ack = 1'b1;
                end
                io_wait--;
            end
        end
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    // Returns on a falling edge with cpu_ready high
    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!cpu_ready && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!cpu_ready) begin
            $display("Timeout: cpu_ready stayed low for 100 cycles");
            timeouts++;
        end
    endtask

    // Sampled just after the falling edge, once ack from the models has settled
    task automatic wait_data(output int lat);
        lat = 1;
        #1;
        while (!cpu_data_valid && lat < 100) begin
            @(negedge clk);
            #1;
            lat++;
        end
        if (!cpu_data_valid) begin
            $display("Timeout: no load result within 100 cycles");
            timeouts++;
        end
    endtask

    task automatic issue(input logic unc, input logic [31:0] addr, input logic [31:0] data,
                         input logic [3:0] strb);
        wait_ready();
        cpu_valid = 1'b1;
        cpu_uncached = unc;
        cpu_addr = addr;
        cpu_wdata = data;
        cpu_wstrb = strb;
        @(negedge clk);
        cpu_valid = 1'b0;
    endtask

    task automatic do_load(input logic unc, input logic [31:0] addr, output int lat);
        issue(unc, addr, '0, '0);
        wait_data(lat);
        check("load data", ref_mem[addr[9:2]], cpu_rdata);
    endtask

    task automatic do_store(input logic unc, input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic commit);
        int dc0;
        int io0;
        dc0 = dc_count;
        io0 = io_count;
        issue(unc, addr, data, strb);
        cpu_store_commit = commit;
        cpu_flush = !commit;
        @(negedge clk);
        cpu_store_commit = 1'b0;
        cpu_flush = 1'b0;
        wait_ready();
        if (commit) begin
            ref_mem[addr[9:2]] = merge(ref_mem[addr[9:2]], data, strb);
            check("store sel", 32'(strb), 32'(unc ? io_last_sel : dc_last_sel));
        end
        check("store dc cycles", dc0 + (commit && !unc), dc_count);
        check("store io cycles", io0 + (commit && unc), io_count);
        check("store memory", ref_mem[addr[9:2]], bus_mem[addr[9:2]]);
    endtask

    initial begin
        int          n;
        int          lat;
        int          dc0;
        int          io0;
        int          op;
        logic [3:0]  strb;
        seed = 32'h12e5_7bd0;
        errors = 0;
        timeouts = 0;
        cpu_valid = 1'b0;
        cpu_uncached = 1'b0;
        cpu_addr = '0;
        cpu_wdata = '0;
        cpu_wstrb = '0;
        cpu_flush = 1'b0;
        cpu_store_commit = 1'b0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = fill_word(i);
            delay_tab[i] = 2'($random(seed));
        end
        n = 0;
        @(posedge clk);
        while (rst && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (rst) begin
            $display("Timeout: reset never released");
            timeouts++;
        end
        check("reset cpu_ready", 1, 32'(cpu_ready));
        check("reset cpu_data_valid", 0, 32'(cpu_data_valid));
        check("reset dc_wb_cyc", 0, 32'(dc_wb_cyc));
        check("reset io_wb_cyc", 0, 32'(io_wb_cyc));

        // Miss then hit on a fresh line
        dc0 = dc_count;
        do_load(1'b0, 32'h0000_0020, lat);
        check("miss dc cycles", dc0 + 1, dc_count);
        do_load(1'b0, 32'h0000_0020, lat);
        check("hit latency", 1, lat);
        check("hit dc cycles", dc0 + 1, dc_count);

        // Store hit, then eviction by an alias
        do_load(1'b0, cached_addr(1), lat);
        do_store(1'b0, cached_addr(1), $random(seed), 4'b1010, 1'b1);
        do_load(1'b0, cached_addr(1), lat);
        check("merged hit latency", 1, lat);
        do_load(1'b0, cached_addr(5), lat);
        do_load(1'b0, cached_addr(1), lat);

        do_store(1'b0, cached_addr(2), $random(seed), 4'b1111, 1'b0);
        do_store(1'b1, uncached_addr(0), $random(seed), 4'b0011, 1'b0);

        io0 = io_count;
        dc0 = dc_count;
        do_load(1'b1, uncached_addr(3), lat);
        do_load(1'b1, uncached_addr(3), lat);
        check("uncached io cycles", io0 + 2, io_count);
        check("uncached dc cycles", dc0, dc_count);
        do_store(1'b1, uncached_addr(3), $random(seed), 4'b0110, 1'b1);
        do_load(1'b1, uncached_addr(3), lat);

        for (int i = 0; i < 300; i++) begin
            op = {$random(seed)} % 8;
            strb = 4'($random(seed));
            if (strb == '0) begin
                strb = 4'b1111;
            end
            if (op < 4) begin
                do_load(1'b0, cached_addr({$random(seed)} % 16), lat);
            end else if (op == 4) begin
                do_load(1'b1, uncached_addr({$random(seed)} % 8), lat);
            end else if (op == 7) begin
                do_store(1'b1, uncached_addr({$random(seed)} % 8), $random(seed), strb,
                         ({$random(seed)} % 4) != 0);
            end else begin
                do_store(1'b0, cached_addr({$random(seed)} % 16), $random(seed), strb,
                         ({$random(seed)} % 4) != 0);
            end
        end

        $display("Summary: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
